//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -j 0
TOP       = tb_video_crop
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Finished with errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- project.f
src/crop_pkg.sv
src/crop_keys.sv
src/hblank_window.sv
src/vblank_window.sv
src/screen_combine.sv
src/video_crop_top.sv
testbench/video_crop_props.sv
testbench/crop_checker.sv
testbench/tb_video_crop.sv

//--- src/crop_keys.sv
module crop_keys
	import crop_pkg::*;
#(
	parameter int COUNT_W = 12
) (
	input  logic               clk_sys,
	input  logic               reset,
	input  key_byte_t          kbd_data,
	input  logic [1:0]         kbd_type,
	input  logic               kbd_level,
	output logic [COUNT_W-1:0] hbl_l,
	output logic [COUNT_W-1:0] hbl_r,
	output logic [COUNT_W-1:0] vbl_t,
	output logic [COUNT_W-1:0] vbl_b
);

	localparam logic [COUNT_W-1:0] H_INC = COUNT_W'(H_STEP);
	localparam logic [COUNT_W-1:0] V_INC = COUNT_W'(V_STEP);

	key_byte_t  data_q;
	logic [1:0] type_q;
	logic       level_q;
	logic       level_old;
	logic       alt;
	logic       key_evt;

	// A new byte is marked by a toggle of the level
	assign key_evt = (level_q ^ level_old) && (type_q == KEY_TYPE_KBD);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			data_q    <= '0;
			type_q    <= '0;
			level_q   <= 1'b0;
			level_old <= 1'b0;
		end else begin
			data_q    <= kbd_data;                 // Byte stays with its level
			type_q    <= kbd_type;
			level_q   <= kbd_level;
			level_old <= level_q;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hbl_l <= '0;
			hbl_r <= '0;
			vbl_t <= '0;
			vbl_b <= '0;
			alt   <= 1'b0;
		end else if (key_evt) begin
			case (data_q.code)
				{1'b0, KEY_BACKSPACE}: begin
					hbl_l <= '0;
					hbl_r <= '0;
					vbl_t <= '0;
					vbl_b <= '0;
				end
				{1'b0, KEY_UP}: begin
					if (alt) vbl_b <= vbl_b + V_INC;   // Alt moves bottom edge
					else     vbl_t <= vbl_t + V_INC;
				end
				{1'b0, KEY_DOWN}: begin
					if (alt) vbl_b <= vbl_b - V_INC;
					else     vbl_t <= vbl_t - V_INC;
				end
				{1'b0, KEY_LEFT}: begin
					if (alt) hbl_r <= hbl_r + H_INC;   // Alt moves right edge
					else     hbl_l <= hbl_l + H_INC;
				end
				{1'b0, KEY_RIGHT}: begin
					if (alt) hbl_r <= hbl_r - H_INC;
					else     hbl_l <= hbl_l - H_INC;
				end
				default: ;
			endcase
			// Either alt key, held until its release code
			if (data_q.parts.key == KEY_ALT_L || data_q.parts.key == KEY_ALT_R)
				alt <= ~data_q.parts.rel;
		end
	end

endmodule

//--- src/crop_pkg.sv
package crop_pkg;

	// One keyboard byte, either the whole scan code or flag plus key number
	typedef struct packed {
		logic       rel;                         // Set on key release
		logic [6:0] key;
	} key_fields_t;

	typedef union packed {
		logic [7:0]  code;                       // Raw scan code
		key_fields_t parts;
	} key_byte_t;

	localparam logic [1:0] KEY_TYPE_KBD = 2'd3;   // Type field of a keyboard byte

	// Key numbers, press codes have the release flag clear
	localparam logic [6:0] KEY_BACKSPACE = 7'h41;
	localparam logic [6:0] KEY_UP        = 7'h4C;
	localparam logic [6:0] KEY_DOWN      = 7'h4D;
	localparam logic [6:0] KEY_RIGHT     = 7'h4E;
	localparam logic [6:0] KEY_LEFT      = 7'h4F;
	localparam logic [6:0] KEY_ALT_L     = 7'h64;
	localparam logic [6:0] KEY_ALT_R     = 7'h65;

	// Crop step per key press
	localparam int H_STEP = 4;                    // Pixels
	localparam int V_STEP = 1;                    // Lines

	// Forced blank margins and soft blank lead
	localparam int H_FORCE_MARGIN = 8;            // Clocks from line edges
	localparam int SOFT_LEAD      = 2;            // Clocks ahead of hblank edges
	localparam int V_FORCE_TAIL   = 2;            // Lines after sync end

endpackage

//--- src/hblank_window.sv
module hblank_window
	import crop_pkg::*;
#(
	parameter int COUNT_W = 12
) (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               hs,           // Active low
	input  logic               hblank,
	input  logic [COUNT_W-1:0] hbl_l,
	input  logic [COUNT_W-1:0] hbl_r,
	input  logic               line_one,
	output logic               h_blank,
	output logic [COUNT_W-1:0] hsize,
	output logic               line_start
);

	localparam logic [COUNT_W-1:0] LEAD   = COUNT_W'(SOFT_LEAD);
	localparam logic [COUNT_W-1:0] MARGIN = COUNT_W'(H_FORCE_MARGIN);

	logic               hs_d;
	logic               hblank_d;
	logic [COUNT_W-1:0] hcnt;
	logic [COUNT_W-1:0] hend;
	logic [COUNT_W-1:0] hsta;
	logic [COUNT_W-1:0] hmax;
	logic               shbl;
	logic               fhbl;
	logic               hblank_fall;
	logic               hblank_rise;
	logic [COUNT_W-1:0] soft_clr_at;
	logic [COUNT_W-1:0] soft_set_at;
	logic [COUNT_W-1:0] force_set_at;

	assign hblank_fall = hblank_d & ~hblank;
	assign hblank_rise = ~hblank_d & hblank;
	assign line_start  = hs_d & ~hs;

	// Window edges wrap within the counter width
	assign soft_clr_at  = hend + hbl_l - LEAD;
	assign soft_set_at  = hsta + hbl_r - LEAD;
	assign force_set_at = hmax - MARGIN;

	assign h_blank = shbl | fhbl | ~hs;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hs_d     <= 1'b1;
			hblank_d <= 1'b0;
			hcnt     <= '0;
			hend     <= '0;
			hsta     <= '0;
			hmax     <= '0;
			hsize    <= '0;
		end else begin
			hs_d     <= hs;
			hblank_d <= hblank;

			if (!hs) hcnt <= '0;                   // Count restarts in sync
			else     hcnt <= hcnt + 1'b1;

			if (hblank_fall) hend <= hcnt;
			if (hblank_rise) hsta <= hcnt;
			if (line_start)  hmax <= hcnt;         // Full line length

			if (hblank_rise && line_one) hsize <= hcnt - hend;
		end
	end

	// Soft blank follows the crop offsets, forced blank trims the line ends
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			shbl <= 1'b1;
			fhbl <= 1'b1;
		end else begin
			if (hcnt == soft_clr_at) shbl <= 1'b0;
			if (hcnt == soft_set_at) shbl <= 1'b1;

			if (hcnt == MARGIN)       fhbl <= 1'b0;
			if (hcnt == force_set_at) fhbl <= 1'b1;
		end
	end

endmodule

//--- src/screen_combine.sv
module screen_combine #(
	parameter int COUNT_W = 12
) (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               h_blank,
	input  logic               v_blank,
	input  logic               frame_end,
	input  logic [COUNT_W-1:0] hsize,
	input  logic [COUNT_W-1:0] vsize,
	input  logic [COUNT_W-1:0] hbl_l,
	input  logic [COUNT_W-1:0] hbl_r,
	input  logic [COUNT_W-1:0] vbl_t,
	input  logic [COUNT_W-1:0] vbl_b,
	output logic               de,
	output logic [COUNT_W-1:0] scr_hbl_l,
	output logic [COUNT_W-1:0] scr_hbl_r,
	output logic [COUNT_W-1:0] scr_vbl_t,
	output logic [COUNT_W-1:0] scr_vbl_b,
	output logic [COUNT_W-1:0] scr_hsize,
	output logic [COUNT_W-1:0] scr_vsize,
	output logic [6:0]         scr_flg
);

	logic size_changed;

	// Compared against the previous snapshot
	assign size_changed = (scr_hsize != hsize) || (scr_vsize != vsize);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			de <= 1'b0;
		end else begin
			de <= ~(h_blank | v_blank);
		end
	end

	// Snapshot taken as active video starts
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			scr_hbl_l <= '0;
			scr_hbl_r <= '0;
			scr_vbl_t <= '0;
			scr_vbl_b <= '0;
			scr_hsize <= '0;
			scr_vsize <= '0;
			scr_flg   <= '0;
		end else if (frame_end) begin
			scr_hbl_l <= hbl_l;
			scr_hbl_r <= hbl_r;
			scr_vbl_t <= vbl_t;
			scr_vbl_b <= vbl_b;
			scr_hsize <= hsize;
			scr_vsize <= vsize;

			if (size_changed) scr_flg <= scr_flg + 1'b1;   // Mode change count
		end
	end

endmodule

//--- src/vblank_window.sv
module vblank_window
	import crop_pkg::*;
#(
	parameter int COUNT_W = 12
) (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               hs,           // Active low
	input  logic               vblank,
	input  logic               line_start,
	input  logic               h_blank,
	input  logic [COUNT_W-1:0] vbl_t,
	input  logic [COUNT_W-1:0] vbl_b,
	output logic               v_blank,
	output logic [COUNT_W-1:0] vsize,
	output logic               frame_end,
	output logic               line_one
);

	localparam logic [COUNT_W-1:0] TAIL = COUNT_W'(V_FORCE_TAIL);

	logic               hs_d;
	logic               vblank_d;
	logic               h_blank_d;
	logic [COUNT_W-1:0] vcnt;
	logic [COUNT_W-1:0] vend;
	logic [COUNT_W-1:0] vmax;
	logic [COUNT_W-1:0] vs_end;
	logic               svbl;
	logic               fvbl;
	logic               vblank_rise;
	logic               decide;
	logic [COUNT_W-1:0] soft_clr_at;
	logic [COUNT_W-1:0] soft_set_at;
	logic [COUNT_W-1:0] force_set_at;
	logic [COUNT_W-1:0] force_clr_at;

	assign vblank_rise = ~vblank_d & vblank;
	assign frame_end   = vblank_d & ~vblank;
	assign line_one    = (vcnt == COUNT_W'(1));

	// Decide once per line at the end of horizontal blank
	assign decide = (h_blank_d & ~h_blank) | (vcnt == '0);

	assign soft_clr_at  = vend + vbl_t;
	// Top bit set counts the bottom edge back from the frame end
	assign soft_set_at  = vbl_b[COUNT_W-1] ? vmax + vbl_b : vbl_b;
	assign force_set_at = vmax - 1'b1;
	assign force_clr_at = vs_end + TAIL;

	assign v_blank = svbl | fvbl;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hs_d      <= 1'b1;
			vblank_d  <= 1'b0;
			h_blank_d <= 1'b1;
			vcnt      <= '0;
			vend      <= '0;
			vmax      <= '0;
			vs_end    <= '0;
			vsize     <= '0;
		end else begin
			hs_d      <= hs;
			vblank_d  <= vblank;
			h_blank_d <= h_blank;

			if (line_start)  vcnt <= vcnt + 1'b1;
			if (vblank_rise) vcnt <= '0;           // New frame wins

			if (frame_end)   vend <= vcnt;
			if (~hs_d & hs)  vs_end <= vcnt;       // End of sync pulse
			if (vblank_rise) begin
				vmax  <= vcnt;
				vsize <= vcnt - vend;
			end
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			svbl <= 1'b1;
			fvbl <= 1'b1;
		end else if (decide) begin
			if (vcnt == soft_clr_at) svbl <= 1'b0;
			if (vcnt == soft_set_at) svbl <= 1'b1;

			if (vcnt == force_set_at) fvbl <= 1'b1;
			if (vcnt == force_clr_at) fvbl <= 1'b0;
		end
	end

endmodule

//--- src/video_crop_top.sv
module video_crop_top
	import crop_pkg::*;
#(
	parameter int COUNT_W = 12
) (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               hs,
	input  logic               hblank,
	input  logic               vblank,
	input  key_byte_t          kbd_data,
	input  logic [1:0]         kbd_type,
	input  logic               kbd_level,
	output logic               de,
	output logic [COUNT_W-1:0] scr_hbl_l,
	output logic [COUNT_W-1:0] scr_hbl_r,
	output logic [COUNT_W-1:0] scr_vbl_t,
	output logic [COUNT_W-1:0] scr_vbl_b,
	output logic [COUNT_W-1:0] scr_hsize,
	output logic [COUNT_W-1:0] scr_vsize,
	output logic [6:0]         scr_flg
);

	logic [COUNT_W-1:0] hbl_l;
	logic [COUNT_W-1:0] hbl_r;
	logic [COUNT_W-1:0] vbl_t;
	logic [COUNT_W-1:0] vbl_b;
	logic               h_blank;
	logic               v_blank;
	logic [COUNT_W-1:0] hsize;
	logic [COUNT_W-1:0] vsize;
	logic               line_start;
	logic               line_one;
	logic               frame_end;

	crop_keys #(.COUNT_W(COUNT_W)) crop_keys_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.kbd_data  (kbd_data),
		.kbd_type  (kbd_type),
		.kbd_level (kbd_level),
		.hbl_l     (hbl_l),
		.hbl_r     (hbl_r),
		.vbl_t     (vbl_t),
		.vbl_b     (vbl_b)
	);

	hblank_window #(.COUNT_W(COUNT_W)) hblank_window_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.hs         (hs),
		.hblank     (hblank),
		.hbl_l      (hbl_l),
		.hbl_r      (hbl_r),
		.line_one   (line_one),
		.h_blank    (h_blank),
		.hsize      (hsize),
		.line_start (line_start)
	);

	vblank_window #(.COUNT_W(COUNT_W)) vblank_window_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.hs         (hs),
		.vblank     (vblank),
		.line_start (line_start),
		.h_blank    (h_blank),
		.vbl_t      (vbl_t),
		.vbl_b      (vbl_b),
		.v_blank    (v_blank),
		.vsize      (vsize),
		.frame_end  (frame_end),
		.line_one   (line_one)
	);

	screen_combine #(.COUNT_W(COUNT_W)) screen_combine_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.h_blank   (h_blank),
		.v_blank   (v_blank),
		.frame_end (frame_end),
		.hsize     (hsize),
		.vsize     (vsize),
		.hbl_l     (hbl_l),
		.hbl_r     (hbl_r),
		.vbl_t     (vbl_t),
		.vbl_b     (vbl_b),
		.de        (de),
		.scr_hbl_l (scr_hbl_l),
		.scr_hbl_r (scr_hbl_r),
		.scr_vbl_t (scr_vbl_t),
		.scr_vbl_b (scr_vbl_b),
		.scr_hsize (scr_hsize),
		.scr_vsize (scr_vsize),
		.scr_flg   (scr_flg)
	);

endmodule

//--- testbench/crop_checker.sv
module crop_checker
	import crop_pkg::*;
#(
	parameter int COUNT_W = 12
) (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               hs,
	input  logic               hblank,
	input  logic               vblank,
	input  key_byte_t          kbd_data,
	input  logic [1:0]         kbd_type,
	input  logic               kbd_level,
	input  logic               de,
	input  logic [COUNT_W-1:0] scr_hbl_l,
	input  logic [COUNT_W-1:0] scr_hbl_r,
	input  logic [COUNT_W-1:0] scr_vbl_t,
	input  logic [COUNT_W-1:0] scr_vbl_b,
	input  logic [COUNT_W-1:0] scr_hsize,
	input  logic [COUNT_W-1:0] scr_vsize,
	input  logic [6:0]         scr_flg,
	output int                 checks,
	output int                 key_errs,
	output int                 size_errs,
	output int                 flg_errs,
	output int                 de_errs
);

	typedef struct packed {
		logic               alt;
		logic [COUNT_W-1:0] l;
		logic [COUNT_W-1:0] r;
		logic [COUNT_W-1:0] t;
		logic [COUNT_W-1:0] b;
	} crop_state_t;

	crop_state_t        off_vis;                 // Offsets as the DUT shows them
	crop_state_t        off_pend;
	crop_state_t        off_now;
	crop_state_t        off_snap;
	logic               pend;
	logic               level_d;
	logic               hs_d;
	logic               vb_d;
	logic [COUNT_W-1:0] line_idx;
	logic [COUNT_W-1:0] vend_m;
	logic [COUNT_W-1:0] vmax_m;
	logic [COUNT_W-1:0] vsize_m;
	logic [COUNT_W-1:0] exp_h;
	logic [COUNT_W-1:0] exp_v;
	logic [COUNT_W-1:0] prev_h;
	logic [COUNT_W-1:0] prev_v;
	logic [6:0]         flg_m;
	logic               svbl_m;
	logic               fvbl_m;
	logic               open_before;
	logic               open_after;
	logic               check_line;
	logic               snap_check;
	int                 hb_low;
	int                 line1_w;
	int                 de_cnt;
	int                 frame_cnt;

	// Key rules: arrows step an edge, alt picks the far edge, backspace clears
	function automatic crop_state_t apply_key(input crop_state_t s, input logic [7:0] code);
		crop_state_t n;
		logic        rel;
		logic [6:0]  key;
		n   = s;
		rel = code[7];
		key = code[6:0];
		if (!rel) begin
			case (key)
				KEY_BACKSPACE: begin
					n.l = '0;
					n.r = '0;
					n.t = '0;
					n.b = '0;
				end
				KEY_UP: begin
					if (s.alt) n.b = s.b + COUNT_W'(V_STEP);
					else       n.t = s.t + COUNT_W'(V_STEP);
				end
				KEY_DOWN: begin
					if (s.alt) n.b = s.b - COUNT_W'(V_STEP);
					else       n.t = s.t - COUNT_W'(V_STEP);
				end
				KEY_LEFT: begin
					if (s.alt) n.r = s.r + COUNT_W'(H_STEP);
					else       n.l = s.l + COUNT_W'(H_STEP);
				end
				KEY_RIGHT: begin
					if (s.alt) n.r = s.r - COUNT_W'(H_STEP);
					else       n.l = s.l - COUNT_W'(H_STEP);
				end
				default: ;
			endcase
		end
		if (key == KEY_ALT_L || key == KEY_ALT_R)
			n.alt = !rel;
		return n;
	endfunction

	task automatic check_value(input string what, input int got, input int exp, inout int errs);
		checks++;
		if (got != exp) begin
			errs++;
			$display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	always @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			off_vis = '0;
			off_pend = '0;
			off_snap = '0;
			pend = 1'b0;
			level_d = 1'b0;
			hs_d = 1'b1;
			vb_d = 1'b0;
			line_idx = '0;
			vend_m = '0;
			vmax_m = '0;
			vsize_m = '0;
			prev_h = '0;
			prev_v = '0;
			flg_m = '0;
			svbl_m = 1'b1;
			fvbl_m = 1'b1;
			open_before = 1'b0;
			open_after = 1'b0;
			check_line = 1'b0;
			snap_check = 1'b0;
			hb_low = 0;
			line1_w = 0;
			de_cnt = 0;
			frame_cnt = 0;
		end else begin
			// Snapshot latched on the previous edge is stable now
			if (snap_check) begin
				check_value("scr_hbl_l", int'(scr_hbl_l), int'(off_snap.l), key_errs);
				check_value("scr_hbl_r", int'(scr_hbl_r), int'(off_snap.r), key_errs);
				check_value("scr_vbl_t", int'(scr_vbl_t), int'(off_snap.t), key_errs);
				check_value("scr_vbl_b", int'(scr_vbl_b), int'(off_snap.b), key_errs);
				check_value("scr_hsize", int'(scr_hsize), int'(exp_h), size_errs);
				check_value("scr_vsize", int'(scr_vsize), int'(exp_v), size_errs);
				check_value("scr_flg", int'(scr_flg), int'(flg_m), flg_errs);
				snap_check = 1'b0;
			end

			// Toggle is registered once, the offset moves one edge later
			off_now = off_vis;
			if (pend) off_vis = off_pend;
			pend = 1'b0;
			if (kbd_level != level_d && kbd_type == KEY_TYPE_KBD) begin
				pend = 1'b1;
				off_pend = apply_key(off_vis, kbd_data.code);
			end
			level_d = kbd_level;

			if (hs_d && !hs) begin
				if (check_line && open_before == open_after) begin
					check_value("de count per line", de_cnt, open_before ? hb_low : 0, de_errs);
				end
				if (line_idx == COUNT_W'(1)) line1_w = hb_low;
			end

			if (vb_d && !vblank) begin                 // End of vertical blank
				vend_m = line_idx;
				off_snap = off_now;
				exp_h = COUNT_W'(line1_w);
				exp_v = vsize_m;
				if (exp_h != prev_h || exp_v != prev_v) flg_m = flg_m + 7'd1;
				prev_h = exp_h;
				prev_v = exp_v;
				frame_cnt++;
				snap_check = 1'b1;
			end

			if (!vb_d && vblank) begin
				vmax_m = line_idx;
				vsize_m = line_idx - vend_m;
				line_idx = '0;
			end else if (hs_d && !hs) begin
				line_idx = line_idx + 1'b1;
			end

			if (hs_d && !hs) begin
				// Line decision, vs_end equals the line taken at hs rise
				open_before = !(svbl_m || fvbl_m);
				if (line_idx == vend_m + off_vis.t) svbl_m = 1'b0;
				if (line_idx == (off_vis.b[COUNT_W-1] ? vmax_m + off_vis.b : off_vis.b))
					svbl_m = 1'b1;
				if (line_idx == vmax_m - 1'b1) fvbl_m = 1'b1;
				if (line_idx == line_idx + COUNT_W'(V_FORCE_TAIL)) fvbl_m = 1'b0;
				open_after = !(svbl_m || fvbl_m);
				check_line = (frame_cnt >= 3) && (off_vis[4*COUNT_W-1:0] == '0);
				hb_low = 0;
				de_cnt = 0;
			end

			if (!hblank) hb_low++;
			if (de) de_cnt++;
			hs_d = hs;
			vb_d = vblank;
		end
	end

endmodule

//--- testbench/tb_video_crop.sv
module tb_video_crop;
	import crop_pkg::*;

	localparam int COUNT_W   = 12;
	localparam int LINES     = 60;
	localparam int VBL_LINES = 10;
	localparam int HS_LEN    = 30;
	localparam int HBL_LEN   = 80;
	localparam int FRAMES    = 13;
	localparam int MAX_TOTAL = 480;
	localparam longint WATCHDOG = (longint'(FRAMES) * LINES * MAX_TOTAL + 10000) * 100;

	logic               clk_sys = 1'b0;
	logic               reset;
	logic               hs;
	logic               hblank;
	logic               vblank;
	key_byte_t          kbd_data;
	logic [1:0]         kbd_type;
	logic               kbd_level;
	logic               de;
	logic [COUNT_W-1:0] scr_hbl_l;
	logic [COUNT_W-1:0] scr_hbl_r;
	logic [COUNT_W-1:0] scr_vbl_t;
	logic [COUNT_W-1:0] scr_vbl_b;
	logic [COUNT_W-1:0] scr_hsize;
	logic [COUNT_W-1:0] scr_vsize;
	logic [6:0]         scr_flg;
	int                 checks;
	int                 key_errs;
	int                 size_errs;
	int                 flg_errs;
	int                 de_errs;
	int                 assert_errs;
	logic [31:0]        rng = 32'd46093;
	logic               keys_on = 1'b0;
	logic               clear_req = 1'b0;
	int                 key_gap = 0;

	always #50 clk_sys = ~clk_sys;

	video_crop_top #(.COUNT_W(COUNT_W)) video_crop_top_inst (
		.clk_sys(clk_sys), .reset(reset), .hs(hs), .hblank(hblank), .vblank(vblank),
		.kbd_data(kbd_data), .kbd_type(kbd_type), .kbd_level(kbd_level), .de(de),
		.scr_hbl_l(scr_hbl_l), .scr_hbl_r(scr_hbl_r), .scr_vbl_t(scr_vbl_t),
		.scr_vbl_b(scr_vbl_b), .scr_hsize(scr_hsize), .scr_vsize(scr_vsize),
		.scr_flg(scr_flg)
	);

	crop_checker #(.COUNT_W(COUNT_W)) crop_checker_inst (
		.clk_sys(clk_sys), .reset(reset), .hs(hs), .hblank(hblank), .vblank(vblank),
		.kbd_data(kbd_data), .kbd_type(kbd_type), .kbd_level(kbd_level), .de(de),
		.scr_hbl_l(scr_hbl_l), .scr_hbl_r(scr_hbl_r), .scr_vbl_t(scr_vbl_t),
		.scr_vbl_b(scr_vbl_b), .scr_hsize(scr_hsize), .scr_vsize(scr_vsize),
		.scr_flg(scr_flg), .checks(checks), .key_errs(key_errs), .size_errs(size_errs),
		.flg_errs(flg_errs), .de_errs(de_errs)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Random byte, some with the wrong type or without a level toggle
	task automatic send_random_key();
		int sel;
		rng = xorshift32(rng);
		sel = int'(rng % 32'd13);
		case (sel)
			0, 4:    kbd_data.code = {1'b0, KEY_UP};
			1:       kbd_data.code = {1'b0, KEY_DOWN};
			2, 5:    kbd_data.code = {1'b0, KEY_LEFT};
			3:       kbd_data.code = {1'b0, KEY_RIGHT};
			6:       kbd_data.code = {1'b0, KEY_ALT_L};
			7:       kbd_data.code = {1'b1, KEY_ALT_L};
			8:       kbd_data.code = {1'b0, KEY_ALT_R};
			9:       kbd_data.code = {1'b1, KEY_ALT_R};
			10:      kbd_data.code = {1'b0, KEY_BACKSPACE};
			11:      kbd_data.code = {1'b1, KEY_UP};
			default: kbd_data.code = rng[31:24];
		endcase
		kbd_type = (rng[10:8] == 3'd0) ? 2'd1 : KEY_TYPE_KBD;
		if (rng[13:11] != 3'd0) kbd_level = ~kbd_level;
	endtask

	task automatic key_tick();
		if (clear_req) begin
			kbd_data.code = {1'b0, KEY_BACKSPACE};
			kbd_type = KEY_TYPE_KBD;
			kbd_level = ~kbd_level;
			clear_req = 1'b0;
		end else if (keys_on) begin
			key_gap++;
			if (key_gap == 20) begin                 // Keys 20 cycles apart
				key_gap = 0;
				send_random_key();
			end
		end
	endtask

	// Blank window 40 clocks either side of the line start, sync at the start
	task automatic run_frame(input int total);
		for (int line = 0; line < LINES; line++) begin
			for (int p = 0; p < total; p++) begin
				@(posedge clk_sys);
				#10;
				hs = (p >= HS_LEN);
				hblank = (p < HBL_LEN / 2) || (p >= total - HBL_LEN / 2);
				vblank = (line < VBL_LINES);
				key_tick();
			end
		end
	endtask

	initial begin
		#(WATCHDOG);
		$display("Watchdog expired before all frames were sent");
		$display("Finished with errors");
		$finish;
	end

	initial begin
		reset = 1'b1;
		hs = 1'b1;
		hblank = 1'b0;
		vblank = 1'b0;
		kbd_data = '0;
		kbd_type = 2'd0;
		kbd_level = 1'b0;
		repeat (2) @(posedge clk_sys);
		#10;
		reset = 1'b0;

		repeat (4) run_frame(400);
		keys_on = 1'b1;
		repeat (3) run_frame(400);
		keys_on = 1'b0;
		clear_req = 1'b1;                          // Offsets back to zero
		repeat (3) run_frame(480);
		repeat (3) run_frame(400);
		repeat (5) @(posedge clk_sys);

		assert_errs = video_crop_top_inst.video_crop_props_inst.fail_cnt;
		$display("Checks %0d, errors: key %0d, size %0d, mode %0d, de %0d, assertion %0d",
			checks, key_errs, size_errs, flg_errs, de_errs, assert_errs);
		if (key_errs + size_errs + flg_errs + de_errs + assert_errs == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- testbench/video_crop_props.sv
module video_crop_props #(
	parameter int COUNT_W = 12
) (
	input logic               clk_sys,
	input logic               reset,
	input logic               kbd_level,
	input logic               de,
	input logic               v_blank,
	input logic               frame_end,
	input logic [6:0]         scr_flg,
	input logic [COUNT_W-1:0] hbl_l,
	input logic [COUNT_W-1:0] hbl_r,
	input logic [COUNT_W-1:0] vbl_t,
	input logic [COUNT_W-1:0] vbl_b
);

	logic [4*COUNT_W-1:0] offsets;
	int                   fail_cnt = 0;

	assign offsets = {hbl_l, hbl_r, vbl_t, vbl_b};

	// de is registered, so it follows v_blank one cycle late
	de_in_vblank: assert property (@(posedge clk_sys) disable iff (reset)
		$past(v_blank) |-> !de)
		else begin
			fail_cnt++;
			$error("de high while the registered v_blank was high");
		end

	flg_after_frame_end: assert property (@(posedge clk_sys) disable iff (reset)
		!$stable(scr_flg) |-> $past(frame_end))
		else begin
			fail_cnt++;
			$error("scr_flg changed without a frame end one cycle earlier");
		end

	offsets_need_toggle: assert property (@(posedge clk_sys) disable iff (reset)
		!$stable(offsets) |-> ($past(kbd_level, 2) != $past(kbd_level, 3)))
		else begin
			fail_cnt++;
			$error("Crop offsets changed without a keyboard level toggle");
		end

endmodule

bind video_crop_top video_crop_props #(.COUNT_W(COUNT_W)) video_crop_props_inst (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.kbd_level (kbd_level),
	.de        (de),
	.v_blank   (v_blank),
	.frame_end (frame_end),
	.scr_flg   (scr_flg),
	.hbl_l     (hbl_l),
	.hbl_r     (hbl_r),
	.vbl_t     (vbl_t),
	.vbl_b     (vbl_b)
);
